//--- verilog/boxcar_pkg.sv
// Shared widths, delay depth and APB register map for the boxcar filter, imported by every block
`default_nettype none

package boxcar_pkg;

  // --------------------------------------------------------------------------
  // Datapath widths
  // --------------------------------------------------------------------------

  // Input sample width, two's complement
  localparam int sample_w = 16;

  // Delay or window length width, N runs 1 to 63
  localparam int len_w = 6;

  // Number of history entries in the delay RAM
  localparam int delay_depth = 64;

  // Occupancy counter needs one extra bit to reach delay_depth
  localparam int cnt_w = len_w + 1;

  // Running sum width, 63 full-scale samples fit without overflow
  localparam int acc_w = sample_w + len_w;

  // --------------------------------------------------------------------------
  // APB register map
  // --------------------------------------------------------------------------

  localparam int apb_addr_w = 4;

  // Bit 0 is the enable bit
  localparam logic [apb_addr_w-1:0] reg_ctrl = 4'h0;

  // Bits 5 to 0 hold the window length
  localparam logic [apb_addr_w-1:0] reg_length = 4'h4;

  // Read only, latest sum sign-extended to 32 bits
  localparam logic [apb_addr_w-1:0] reg_last_sum = 4'h8;

  // Window length after reset
  localparam logic [len_w-1:0] length_reset = 6'd8;

endpackage

`default_nettype wire

//--- verilog/sample_ram.sv
// Inferred two-port sample RAM, one write port and one registered read port, used by the delay line
`default_nettype none

module sample_ram (
  input  logic                                    clk,
  input  logic                                    we,
  input  logic        [boxcar_pkg::len_w-1:0]     waddr,
  input  logic signed [boxcar_pkg::sample_w-1:0]  wdata,
  input  logic        [boxcar_pkg::len_w-1:0]     raddr,
  output logic signed [boxcar_pkg::sample_w-1:0]  rdata
);

  import boxcar_pkg::*;

  // History storage, no reset so it maps onto block or distributed RAM
  logic signed [sample_w-1:0] mem [delay_depth];

  // --------------------------------------------------------------------------
  // Write port
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------

  // Registered read, data shows up one cycle after raddr
  // Same-address collision returns the old word (read before write)
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- verilog/variable_delay_line.sv
// Circular-buffer delay line returning the sample from delay strobes ago, or zero before it exists
`default_nettype none

module variable_delay_line (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    clear,
  input  logic                                    stb,
  input  logic signed [boxcar_pkg::sample_w-1:0]  data_in,
  input  logic        [boxcar_pkg::len_w-1:0]     delay,
  output logic signed [boxcar_pkg::sample_w-1:0]  data_out
);

  import boxcar_pkg::*;

  // Write pointer, wraps naturally since depth is a power of two
  logic [len_w-1:0] wr_ptr;

  // Read address for the sample delay strobes back
  logic [len_w-1:0] rd_addr;

  // Samples held since last clear, saturates at delay_depth
  logic [cnt_w-1:0] occupied;

  // Set when the requested sample predates the history
  logic use_zero;

  // Raw RAM output
  logic signed [sample_w-1:0] ram_data;

  // --------------------------------------------------------------------------
  // Pointer and occupancy tracking
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr   <= '0;
      occupied <= '0;
    end else if (stb) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (occupied != cnt_w'(delay_depth)) begin
        occupied <= occupied + 1'b1;
      end
    end
  end

  // Modulo-64 subtraction lands on the entry written delay strobes ago
  assign rd_addr = wr_ptr - delay;

  // --------------------------------------------------------------------------
  // Negative-index detection
  // --------------------------------------------------------------------------

  // Sample k needs k-delay >= 0, i.e. at least delay samples already held
  // Registered alongside the RAM read so both line up in the next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      use_zero <= 1'b1;
    end else begin
      use_zero <= (occupied < {1'b0, delay});
    end
  end

  // --------------------------------------------------------------------------
  // History RAM
  // --------------------------------------------------------------------------

  sample_ram ram_i (
    .clk   (clk),
    .we    (stb),
    .waddr (wr_ptr),
    .wdata (data_in),
    .raddr (rd_addr),
    .rdata (ram_data)
  );

  // Empty history reads as zero so partial sums stay exact
  assign data_out = use_zero ? '0 : ram_data;

endmodule

`default_nettype wire

//--- verilog/boxcar_accumulator.sv
// Two-stage running-sum pipeline adding the new sample and subtracting the delayed one
`default_nettype none

module boxcar_accumulator (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    clear,
  input  logic                                    stb,
  input  logic signed [boxcar_pkg::sample_w-1:0]  sample_in,
  input  logic signed [boxcar_pkg::sample_w-1:0]  delayed_sample,
  output logic signed [boxcar_pkg::acc_w-1:0]     sum_out,
  output logic                                    sum_stb
);

  import boxcar_pkg::*;

  // Stage one holding register, lines up with the delay line read
  logic signed [sample_w-1:0] sample_q;
  logic                       valid_q;

  // Running sum of the current window
  logic signed [acc_w-1:0] sum_q;

  // --------------------------------------------------------------------------
  // Stage one
  // --------------------------------------------------------------------------

  // Payload register, only meaningful while valid_q is set
  always_ff @(posedge clk) begin
    if (stb) begin
      sample_q <= sample_in;
    end
  end

  // Clear drops any sample caught in this stage
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= stb;
    end
  end

  // --------------------------------------------------------------------------
  // Stage two
  // --------------------------------------------------------------------------

  // All operands signed so both samples sign-extend to acc_w
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sum_q   <= '0;
      sum_stb <= 1'b0;
    end else begin
      sum_stb <= valid_q;
      if (valid_q) begin
        sum_q <= sum_q + sample_q - delayed_sample;
      end
    end
  end

  assign sum_out = sum_q;

endmodule

`default_nettype wire

//--- verilog/boxcar_regs.sv
// APB slave holding CTRL, LENGTH and LAST_SUM and issuing the history clear pulse
`default_nettype none

module boxcar_regs (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic        [boxcar_pkg::apb_addr_w-1:0] paddr,
  input  logic        [31:0]                    pwdata,
  output logic        [31:0]                    prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  input  logic signed [boxcar_pkg::acc_w-1:0]   last_sum,
  output logic                                  enable,
  output logic        [boxcar_pkg::len_w-1:0]   length,
  output logic                                  clear
);

  import boxcar_pkg::*;

  // Access phase strobe
  logic access;

  // Address decode
  logic hit_ctrl;
  logic hit_length;
  logic hit_last_sum;
  logic unmapped;

  // Write that passed the error check
  logic wr_ok;

  // Incoming length with zero folded to one
  logic [len_w-1:0] length_wr;

  // --------------------------------------------------------------------------
  // Decode and response
  // --------------------------------------------------------------------------

  assign access       = psel & penable;
  assign hit_ctrl     = (paddr == reg_ctrl);
  assign hit_length   = (paddr == reg_length);
  assign hit_last_sum = (paddr == reg_last_sum);
  assign unmapped     = ~(hit_ctrl | hit_length | hit_last_sum);

  // Zero wait states, every transfer completes in its access phase
  assign pready = 1'b1;

  // LAST_SUM is read only, writing it is an error
  assign pslverr = access & (unmapped | (pwrite & hit_last_sum));

  assign wr_ok = access & pwrite & ~pslverr;

  assign length_wr = (pwdata[len_w-1:0] == '0) ? len_w'(1) : pwdata[len_w-1:0];

  // --------------------------------------------------------------------------
  // Register storage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= 1'b0;
      length <= length_reset;
    end else if (wr_ok) begin
      if (hit_ctrl) begin
        enable <= pwdata[0];
      end
      if (hit_length) begin
        length <= length_wr;
      end
    end
  end

  // One-cycle clear after any good write to CTRL or LENGTH
  always_ff @(posedge clk) begin
    if (reset) begin
      clear <= 1'b0;
    end else begin
      clear <= wr_ok & (hit_ctrl | hit_length);
    end
  end

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------

  // Combinational from paddr, zero when not selected or unmapped
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        reg_ctrl:     prdata = {31'b0, enable};
        reg_length:   prdata = {{(32 - len_w){1'b0}}, length};
        reg_last_sum: prdata = {{(32 - acc_w){last_sum[acc_w-1]}}, last_sum};
        default:      prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/boxcar_filter_top.sv
// Boxcar filter top level joining the APB register block, delay line and accumulator
`default_nettype none

module boxcar_filter_top (
  input  logic                                     clk,
  input  logic                                     reset,
  // APB slave
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic        [boxcar_pkg::apb_addr_w-1:0] paddr,
  input  logic        [31:0]                       pwdata,
  output logic        [31:0]                       prdata,
  output logic                                     pready,
  output logic                                     pslverr,
  // Sample stream
  input  logic signed [boxcar_pkg::sample_w-1:0]   sample_in,
  input  logic                                     sample_stb,
  output logic signed [boxcar_pkg::acc_w-1:0]      sum_out,
  output logic                                     sum_stb
);

  import boxcar_pkg::*;

  // Control from the register block
  logic             enable;
  logic [len_w-1:0] length;
  logic             clear;

  // Strobes are ignored while disabled
  logic accepted_stb;

  logic signed [sample_w-1:0] delayed_sample;

  assign accepted_stb = sample_stb & enable;

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------

  boxcar_regs regs_i (
    .clk      (clk),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .last_sum (sum_out),
    .enable   (enable),
    .length   (length),
    .clear    (clear)
  );

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------

  // Returns the sample leaving the window, zero while the window fills
  variable_delay_line delay_i (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .stb      (accepted_stb),
    .data_in  (sample_in),
    .delay    (length),
    .data_out (delayed_sample)
  );

  boxcar_accumulator acc_i (
    .clk            (clk),
    .reset          (reset),
    .clear          (clear),
    .stb            (accepted_stb),
    .sample_in      (sample_in),
    .delayed_sample (delayed_sample),
    .sum_out        (sum_out),
    .sum_stb        (sum_stb)
  );

endmodule

`default_nettype wire

//--- testbench/boxcar_assertions.sv
// Bound checks on the boxcar filter top level for sum strobe timing and the APB response
`default_nettype none

module boxcar_assertions (
  input logic                              clk,
  input logic                              reset,
  input logic                              accepted_stb,
  input logic                              clear,
  input logic                              sum_stb,
  input logic                              psel,
  input logic                              penable,
  input logic                              pwrite,
  input logic [boxcar_pkg::apb_addr_w-1:0] paddr,
  input logic                              pready,
  input logic                              pslverr
);

  import boxcar_pkg::*;

  // Failures so far, polled by the testbench
  int error_count = 0;

  // Access phase to an unmapped address, or a write to the read-only sum
  logic bad_access;

  assign bad_access = psel && penable &&
                      (!(paddr inside {reg_ctrl, reg_length, reg_last_sum}) ||
                       (pwrite && paddr == reg_last_sum));

  // --------------------------------------------------------------------------
  // Sum strobe timing
  // --------------------------------------------------------------------------

  // Strobe with no clear during its two pipeline cycles
  sum_after_stb: assert property (@(posedge clk) disable iff (reset)
    $past(accepted_stb && !clear, 2) && $past(!clear) |-> sum_stb)
    else begin
      error_count++;
      $error("sum_stb missing two cycles after an accepted strobe");
    end

  // Never a sum without a strobe two cycles back
  stb_before_sum: assert property (@(posedge clk) disable iff (reset)
    sum_stb |-> $past(accepted_stb, 2))
    else begin
      error_count++;
      $error("sum_stb without an accepted strobe two cycles earlier");
    end

  reset_quiet: assert property (@(posedge clk) reset |=> !sum_stb)
    else begin
      error_count++;
      $error("sum_stb high in the cycle after reset");
    end

  // --------------------------------------------------------------------------
  // APB response
  // --------------------------------------------------------------------------

  ready_high: assert property (@(posedge clk) pready)
    else begin
      error_count++;
      $error("pready dropped low");
    end

  err_match: assert property (@(posedge clk) disable iff (reset) pslverr == bad_access)
    else begin
      error_count++;
      $error("pslverr does not match the address decode");
    end

endmodule

bind boxcar_filter_top boxcar_assertions asrt_i (
  .clk          (clk),
  .reset        (reset),
  .accepted_stb (accepted_stb),
  .clear        (clear),
  .sum_stb      (sum_stb),
  .psel         (psel),
  .penable      (penable),
  .pwrite       (pwrite),
  .paddr        (paddr),
  .pready       (pready),
  .pslverr      (pslverr)
);

`default_nettype wire

//--- testbench/boxcar_tb.sv
// Self-checking testbench for the boxcar filter that runs as the simulation top with the bound checks
`default_nettype none

module boxcar_tb;

  import boxcar_pkg::*;

  // Run limit well above the cycles all phases need
  localparam int timeout_cycles = 3000;

  logic                       clk;
  logic                       reset;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [apb_addr_w-1:0]      paddr;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;
  logic signed [sample_w-1:0] sample_in;
  logic                       sample_stb;
  logic signed [acc_w-1:0]    sum_out;
  logic                       sum_stb;

  // Reference model of accepted samples since the last clear and sums in flight
  int   history[$];
  int   expected[$];
  int   model_length;
  logic model_enable;
  int   last_sum;
  int   seed;
  int   cycle_count;

  boxcar_filter_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // --------------------------------------------------------------------------
  // Timeout and output monitor
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("Timeout, test still running after %0d cycles", cycle_count));
    end
  end

  // Outputs are stable mid-cycle away from both driving and clock edges
  always @(negedge clk) begin
    if (dut_i.asrt_i.error_count != 0) begin
      abort_run("A bound assertion on the filter failed");
    end
    if (!reset && sum_stb) begin
      if (expected.size() == 0) begin
        abort_run("sum_stb rose with no accepted sample in flight");
      end else begin
        last_sum = expected.pop_front();
        sum_check: assert (sum_out === acc_w'(last_sum)) else begin
          abort_run($sformatf("** Error at %0t: sum_out = %0d, expected %0d",
                              $time, sum_out, last_sum));
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Model and stimulus helpers
  // --------------------------------------------------------------------------

  // Sum of the last N samples, or all of them while the window fills
  function automatic int window_sum();
    int total;
    int i;
    total = 0;
    for (i = 0; i < model_length && i < history.size(); i++) begin
      total += history[history.size() - 1 - i];
    end
    return total;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    value_check: assert (got === exp) else begin
      abort_run($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  // Setup then access phase with the response sampled mid access phase
  task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    step_cycle();
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    step_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [apb_addr_w-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_value("pslverr", 32'(err), 32'(exp_err));
    if (!exp_err && (addr == reg_ctrl || addr == reg_length)) begin
      if (addr == reg_ctrl) begin
        model_enable = data[0];
      end else begin
        model_length = (data[5:0] == 6'd0) ? 1 : int'(data[5:0]);
      end
      history.delete();
      // A strobe in the clear cycle would be dropped
      step_cycle();
    end
  endtask

  task automatic reg_read(input logic [apb_addr_w-1:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
    check_value("pslverr", 32'(err), 32'(exp_err));
    if (!exp_err) begin
      check_value($sformatf("prdata[0x%0h]", addr), rdata, exp_data);
    end
  endtask

  task automatic send_sample(input logic signed [sample_w-1:0] value);
    sample_in  = value;
    sample_stb = 1'b1;
    if (model_enable) begin
      history.push_back(value);
      if (history.size() > delay_depth) begin
        void'(history.pop_front());
      end
      expected.push_back(window_sum());
    end
    step_cycle();
    sample_stb = 1'b0;
  endtask

  // Gap mask picks 0 up to gap_mask idle cycles after each strobe
  task automatic send_burst(input int count, input int gap_mask);
    logic signed [sample_w-1:0] value;
    int                         gap;
    repeat (count) begin
      value = sample_w'($random(seed));
      gap = $random(seed) & gap_mask;
      send_sample(value);
      repeat (gap) step_cycle();
    end
  endtask

  // Idle tail exposes any stray sum_stb
  task automatic wait_for_sums();
    while (expected.size() != 0) begin
      step_cycle();
    end
    repeat (3) step_cycle();
  endtask

  // --------------------------------------------------------------------------
  // Test phases
  // --------------------------------------------------------------------------

  initial begin
    seed         = 32'h37cc;
    cycle_count  = 0;
    model_enable = 1'b0;
    model_length = int'(length_reset);
    last_sum     = 0;
    reset        = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    sample_in    = '0;
    sample_stb   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    step_cycle();

    // Reset values then strobes while disabled
    reg_read(reg_ctrl, 32'h0, 1'b0);
    reg_read(reg_length, 32'd8, 1'b0);
    reg_read(reg_last_sum, 32'h0, 1'b0);
    send_burst(10, 0);
    wait_for_sums();
    reg_write(reg_ctrl, 32'h1, 1'b0);

    // Back-to-back fill and slide with N = 8
    send_burst(100, 0);
    wait_for_sums();
    // Random idle gaps between strobes
    send_burst(100, 3);
    wait_for_sums();

    // Length changes restart from empty history
    reg_write(reg_length, 32'd1, 1'b0);
    reg_read(reg_length, 32'd1, 1'b0);
    send_burst(40, 1);
    wait_for_sums();
    reg_write(reg_length, 32'd63, 1'b0);
    reg_read(reg_length, 32'd63, 1'b0);
    // Long full-scale runs of each sign push the 63-sample sum to both extremes
    repeat (75) send_sample(16'sh7fff);
    repeat (75) send_sample(16'sh8000);
    wait_for_sums();
    reg_write(reg_length, 32'd0, 1'b0);
    reg_read(reg_length, 32'd1, 1'b0);
    send_burst(30, 3);
    wait_for_sums();

    // Negative tail so LAST_SUM needs sign extension
    reg_write(reg_length, 32'd8, 1'b0);
    send_burst(20, 1);
    repeat (8) send_sample(16'sh8000);
    wait_for_sums();
    reg_read(reg_last_sum, 32'(last_sum), 1'b0);

    // Error responses leave the history untouched
    reg_read(4'hc, 32'h0, 1'b1);
    reg_write(reg_last_sum, 32'h1234, 1'b1);
    reg_write(4'hc, 32'h5, 1'b1);
    reg_read(reg_ctrl, 32'h1, 1'b0);
    reg_read(reg_length, 32'd8, 1'b0);
    send_burst(20, 1);
    wait_for_sums();

    if (dut_i.asrt_i.error_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("Bound assertion failures were reported");
    end
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/boxcar_pkg.sv
verilog/sample_ram.sv
verilog/variable_delay_line.sv
verilog/boxcar_accumulator.sv
verilog/boxcar_regs.sv
verilog/boxcar_filter_top.sv
testbench/boxcar_assertions.sv
testbench/boxcar_tb.sv
